//--- tests/muldiv_patterns.hex
// op rs1 rs2 expected_result correction_flag
// op codes 0..3 multiply, 4..7 divide; flag set when the quotient needs correcting
0 00000003 00000005 0000000f 0
4 00000014 00000006 00000003 0
4 12345678 00000000 ffffffff 0
0 ffffffff ffffffff 00000001 0
5 00000064 00000007 0000000e 1
7 00000064 00000007 00000002 1
1 7fffffff 7fffffff 3fffffff 0
7 12345678 00000000 12345678 0
6 ffffffec 00000006 fffffffe 0
1 80000000 80000000 40000000 0
4 80000000 ffffffff 80000000 0
6 80000000 ffffffff 00000000 0
1 80000000 7fffffff c0000000 0
6 ffffff9c 00000007 fffffffe 1
2 80000000 ffffffff 80000000 0
4 80000000 00000001 80000000 1
3 ffffffff ffffffff fffffffe 0
4 00000005 00000007 00000000 1
0 0000ffff 0000ffff fffe0001 0
6 00000000 00000005 00000000 1
5 80000000 ffffffff 00000000 1
7 ffffffff 00000010 0000000f 0

//--- sources.f
rtl/muldiv_pkg.sv
rtl/muldiv_op_route.sv
rtl/muldiv_ctrl.sv
rtl/muldiv_step_cnt.sv
rtl/muldiv_booth_mul.sv
rtl/muldiv_nonrest_div.sv
rtl/muldiv_top.sv
tests/tb_muldiv.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  - rtl/muldiv_pkg.sv
  - rtl/muldiv_op_route.sv
  - rtl/muldiv_ctrl.sv
  - rtl/muldiv_step_cnt.sv
  - rtl/muldiv_booth_mul.sv
  - rtl/muldiv_nonrest_div.sv
  - rtl/muldiv_top.sv
  - target: test
    files:
      - tests/tb_muldiv.sv

//--- tests/tb_muldiv.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the multiply/divide unit: pattern replay, random
// writeback back-pressure, latency and data checks, watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_muldiv;
  import muldiv_pkg::*;

  localparam int NUM_PAT   = 22;
  localparam int PAT_COLS  = 5;
  localparam int CLK_PER   = 4;
  localparam int RST_CYC   = 3;
  // Forty cycles per operation is ample even for a stalled corrected divide
  localparam int WDOG_TIME = NUM_PAT * 40 * CLK_PER + RST_CYC * CLK_PER;

  logic  clk;
  logic  i_rst;
  logic  i_valid;
  op_t   i_op;
  xlen_t i_rs1;
  xlen_t i_rs2;
  logic  i_wbck_ready;
  logic  o_ready;
  logic  o_wbck_valid;
  xlen_t o_wbck_data;

  // Columns per pattern: op, rs1, rs2, expected result, correction flag
  logic [31:0] pat_mem [0:NUM_PAT*PAT_COLS-1];
  logic [31:0] lfsr;
  int          n_pass;
  int          n_fail;

  muldiv_top dut (
    .clk(clk), .i_rst(i_rst),
    .i_valid(i_valid), .i_op(i_op), .i_rs1(i_rs1), .i_rs2(i_rs2),
    .i_wbck_ready(i_wbck_ready),
    .o_ready(o_ready), .o_wbck_valid(o_wbck_valid), .o_wbck_data(o_wbck_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PER/2) clk = ~clk;
    end
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR bit per cycle, zero means the taker stalls
  task automatic draw_ready;
    lfsr = lfsr_step(lfsr);
    i_wbck_ready = lfsr[0];
  endtask

  function automatic string op_name(input op_t op);
    case (op)
      OP_MUL:    op_name = "MUL";
      OP_MULH:   op_name = "MULH";
      OP_MULHSU: op_name = "MULHSU";
      OP_MULHU:  op_name = "MULHU";
      OP_DIV:    op_name = "DIV";
      OP_DIVU:   op_name = "DIVU";
      OP_REM:    op_name = "REM";
      default:   op_name = "REMU";
    endcase
  endfunction

  // Edges from the request to the first cycle the result is on the bus
  function automatic int expect_latency(input op_t op, input xlen_t a, input xlen_t b,
                                        input logic corr);
    logic sgn;
    sgn = (op == OP_DIV) || (op == OP_REM);
    if (!op[2]) begin
      expect_latency = 16;
    end else if ((b == '0) || (sgn && (a == 32'h8000_0000) && (b == 32'hffff_ffff))) begin
      // Zero divisor and signed overflow answer in the request cycle
      expect_latency = 0;
    end else if (corr) begin
      expect_latency = 35;
    end else begin
      expect_latency = 33;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // One operation from request to handshake
  task automatic run_pattern(input int idx);
    op_t   op;
    xlen_t a;
    xlen_t b;
    xlen_t exp_data;
    int    exp_lat;
    int    edges;
    int    lat;
    logic  seen;
    logic  taken;
    logic  bad;
    xlen_t first_data;

    op       = pat_mem[idx*PAT_COLS][2:0];
    a        = pat_mem[idx*PAT_COLS+1];
    b        = pat_mem[idx*PAT_COLS+2];
    exp_data = pat_mem[idx*PAT_COLS+3];
    exp_lat  = expect_latency(op, a, b, pat_mem[idx*PAT_COLS+4][0]);
    edges    = 0;
    lat      = -1;
    seen     = 1'b0;
    taken    = 1'b0;
    bad      = 1'b0;
    first_data = '0;

    @(negedge clk);
    i_valid = 1'b1;
    i_op    = op;
    i_rs1   = a;
    i_rs2   = b;
    draw_ready();
    while (!taken) begin
      // Mid low phase, everything settled for the coming edge
      #1;
      if (o_ready !== (o_wbck_valid & i_wbck_ready)) begin
        $display("ERROR t=%0t o_ready exp %b got %b", $time,
                 o_wbck_valid & i_wbck_ready, o_ready);
        bad = 1'b1;
      end
      if (o_wbck_valid === 1'b1) begin
        if (!seen) begin
          seen       = 1'b1;
          lat        = edges;
          first_data = o_wbck_data;
          if (lat != exp_lat) begin
            $display("ERROR t=%0t o_wbck_valid rise edge exp %0d got %0d", $time,
                     exp_lat, lat);
            bad = 1'b1;
          end
          if (o_wbck_data !== exp_data) begin
            $display("ERROR t=%0t o_wbck_data exp %h got %h", $time, exp_data, o_wbck_data);
            bad = 1'b1;
          end
        end else if (o_wbck_data !== first_data) begin
          // Stalled result must not move
          $display("ERROR t=%0t o_wbck_data exp %h got %h", $time, first_data, o_wbck_data);
          bad = 1'b1;
        end
        if (i_wbck_ready) begin
          taken = 1'b1;
        end
      end else if (seen) begin
        $display("Result at t=%0t was withdrawn before it was taken", $time);
        bad = 1'b1;
      end
      @(negedge clk);
      edges++;
      if (!taken) begin
        draw_ready();
      end
    end

    // Request gone but taker still ready, a second result must not appear
    i_valid      = 1'b0;
    i_wbck_ready = 1'b1;
    #1;
    if ((o_wbck_valid !== 1'b0) || (o_ready !== 1'b0)) begin
      $display("Unit still offers a result at t=%0t after the handshake", $time);
      bad = 1'b1;
    end
    if (bad) begin
      n_fail++;
    end else begin
      n_pass++;
    end
    $display("test %0d %s rs1=%h rs2=%h result=%h after %0d edges: %s", idx, op_name(op),
             a, b, first_data, lat, bad ? "failed" : "ok");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    i_rst        = 1'b1;
    i_valid      = 1'b0;
    // Idle bus carries a divide by zero, which must stay unanswered
    i_op         = OP_DIV;
    i_rs1        = '0;
    i_rs2        = '0;
    i_wbck_ready = 1'b0;
    lfsr         = 32'h7e1b_dc10;
    n_pass       = 0;
    n_fail       = 0;
    for (int k = 0; k < NUM_PAT*PAT_COLS; k++) begin
      pat_mem[k] = 'x;
    end
    $readmemh("tests/muldiv_patterns.hex", pat_mem);
    if (^pat_mem[NUM_PAT*PAT_COLS-1] === 1'bx) begin
      $display("Pattern file holds fewer than %0d operations", NUM_PAT);
      n_fail++;
    end

    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    i_rst        = 1'b0;
    // Taker ready but no request, nothing may be offered
    i_wbck_ready = 1'b1;
    #1;
    if ((o_wbck_valid !== 1'b0) || (o_ready !== 1'b0)) begin
      $display("ERROR t=%0t o_wbck_valid/o_ready exp 0/0 got %b/%b", $time,
               o_wbck_valid, o_ready);
      n_fail++;
      $display("test reset: failed");
    end else begin
      n_pass++;
      $display("test reset: ok");
    end
    i_wbck_ready = 1'b0;

    for (int p = 0; p < NUM_PAT; p++) begin
      run_pattern(p);
    end

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WDOG_TIME);
    $display("Watchdog expired at t=%0t, the unit stopped answering", $time);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- rtl/muldiv_top.sv
////////////////////////////////////////////////////////////////////////////
// Multiply/divide unit top level
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module muldiv_top (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  muldiv_pkg::op_t   i_op,
  input  muldiv_pkg::xlen_t i_rs1,
  input  muldiv_pkg::xlen_t i_rs2,
  input  logic              i_wbck_ready,
  output logic              o_ready,
  output logic              o_wbck_valid,
  output muldiv_pkg::xlen_t o_wbck_data
);
  import muldiv_pkg::*;

  logic  is_mul;
  logic  is_special;
  logic  rs1_signed;
  logic  rs2_signed;
  logic  want_rem;
  xlen_t mul_res;
  xlen_t div_res;
  logic  start;
  logic  run;
  logic  load;
  logic  step;
  logic  check;
  logic  quot_corr;
  logic  remd_corr;
  logic  last;
  logic  need_corr;

  muldiv_op_route u_route (
    .i_op(i_op), .i_rs1(i_rs1), .i_rs2(i_rs2),
    .i_mul_res(mul_res), .i_div_res(div_res),
    .o_is_mul(is_mul), .o_is_special(is_special),
    .o_rs1_signed(rs1_signed), .o_rs2_signed(rs2_signed),
    .o_want_rem(want_rem), .o_wbck_data(o_wbck_data)
  );

  muldiv_ctrl u_ctrl (
    .clk(clk), .i_rst(i_rst),
    .i_valid(i_valid), .i_wbck_ready(i_wbck_ready),
    .i_is_mul(is_mul), .i_is_special(is_special),
    .i_last(last), .i_need_corr(need_corr),
    .o_ready(o_ready), .o_wbck_valid(o_wbck_valid),
    .o_start(start), .o_run(run), .o_load(load), .o_step(step),
    .o_check(check), .o_quot_corr(quot_corr), .o_remd_corr(remd_corr)
  );

  muldiv_step_cnt u_cnt (
    .clk(clk), .i_rst(i_rst),
    .i_start(start), .i_run(run), .i_is_mul(is_mul),
    .o_last(last)
  );

  // Low-half select shares the decoder's want_rem line
  muldiv_booth_mul u_mul (
    .clk(clk), .i_rst(i_rst),
    .i_load(load), .i_step(step), .i_last(last),
    .i_rs1(i_rs1), .i_rs2(i_rs2),
    .i_rs1_signed(rs1_signed), .i_rs2_signed(rs2_signed),
    .i_low_half(want_rem), .o_mul_res(mul_res)
  );

  // Divide signedness is the same for both operands
  muldiv_nonrest_div u_div (
    .clk(clk), .i_rst(i_rst),
    .i_load(load), .i_step(step), .i_last(last),
    .i_check(check), .i_quot_corr(quot_corr), .i_remd_corr(remd_corr),
    .i_rs1(i_rs1), .i_rs2(i_rs2),
    .i_signed(rs1_signed), .i_want_rem(want_rem),
    .o_need_corr(need_corr), .o_div_res(div_res)
  );

endmodule

//--- rtl/muldiv_nonrest_div.sv
////////////////////////////////////////////////////////////////////////////
// Non-restoring divide datapath with remainder check and correction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module muldiv_nonrest_div (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_load,
  input  logic              i_step,
  input  logic              i_last,
  input  logic              i_check,
  input  logic              i_quot_corr,
  input  logic              i_remd_corr,
  input  muldiv_pkg::xlen_t i_rs1,
  input  muldiv_pkg::xlen_t i_rs2,
  input  logic              i_signed,
  input  logic              i_want_rem,
  output logic              o_need_corr,
  output muldiv_pkg::xlen_t o_div_res
);
  import muldiv_pkg::*;

  logic [XLEN:0] remd_q;
  logic [XLEN:0] quot_q;
  logic          remd_sft1_q;
  logic          rs1_sgn;
  logic          rs2_sgn;
  div_acc_t      divisor;
  logic          quot_first;
  logic          prev_quot;
  logic          cur_quot;
  logic [XLEN:0] quot_src;
  logic          fin;
  logic          inc_dec;
  div_acc_t      add_a;
  div_acc_t      add_b;
  logic          add_sub;
  div_acc_t      sum;
  logic          remd_zero;
  logic          remd_neg_divs;
  logic          remd_divs;
  xlen_t         remd_res;

  assign rs1_sgn = i_signed & i_rs1[XLEN-1];
  assign rs2_sgn = i_signed & i_rs2[XLEN-1];
  assign divisor = {rs2_sgn, rs2_sgn, i_rs2};

  // First digit is -1 when the signs differ
  assign quot_first = ~(rs1_sgn ^ rs2_sgn);
  assign prev_quot  = i_load ? quot_first : quot_q[0];

  // Quotient register also holds the dividend bits not yet consumed
  assign quot_src = i_load ? {i_rs1, quot_first} : quot_q;
  assign fin      = i_step & i_last;

  // Remainder sign against divisor sign sets the correction direction
  assign inc_dec = remd_q[XLEN] ^ divisor[XLEN+1];

  ////////////////////////////////////////////////////////////////////////////
  // Shared 34-bit adder
  always_comb begin
    if (i_quot_corr) begin
      add_a   = {quot_q[XLEN], quot_q};
      add_b   = div_acc_t'(1);
      add_sub = inc_dec;
    end else if (i_check | i_remd_corr) begin
      // Check adds the divisor to spot a remainder equal to minus divisor
      add_a   = {remd_q[XLEN], remd_q};
      add_b   = divisor;
      add_sub = i_remd_corr & ~inc_dec;
    end else begin
      // Previous digit picks subtract or add
      add_a   = i_load ? {(XLEN+2){rs1_sgn}} : {remd_sft1_q, remd_q};
      add_b   = divisor;
      add_sub = prev_quot;
    end
  end

  assign sum      = add_sub ? (add_a - add_b) : (add_a + add_b);
  assign cur_quot = ~(sum[XLEN+1] ^ divisor[XLEN+1]);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      remd_q      <= '0;
      quot_q      <= '0;
      remd_sft1_q <= 1'b0;
    end else begin
      if (i_load | i_step) begin
        remd_sft1_q <= sum[XLEN];
        // Last step keeps the unshifted remainder
        remd_q <= fin ? sum[XLEN:0] : {sum[XLEN-1:0], quot_src[XLEN]};
      end
      if (i_quot_corr) begin
        quot_q <= sum[XLEN:0];
      end else if (i_load | i_step) begin
        // Final digit of non-restoring division is always one
        quot_q <= {quot_src[XLEN-1:0], (fin | cur_quot)};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Check and correction
  assign remd_zero     = (remd_q == '0);
  assign remd_neg_divs = (sum == '0);
  assign remd_divs     = (remd_q == divisor[XLEN:0]);

  // Wrong remainder sign, or remainder sits on plus or minus the divisor
  assign o_need_corr = i_check & (((remd_q[XLEN] ^ rs1_sgn) & ~remd_zero)
                                  | remd_neg_divs | remd_divs);

  // Corrected remainder stays combinational until the result is taken
  assign remd_res  = i_remd_corr ? sum[XLEN-1:0] : remd_q[XLEN-1:0];
  assign o_div_res = i_want_rem ? remd_res : quot_q[XLEN-1:0];

endmodule

//--- rtl/muldiv_booth_mul.sv
////////////////////////////////////////////////////////////////////////////
// Radix-4 Booth multiply datapath with its 35-bit adder and product halves
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module muldiv_booth_mul (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_load,
  input  logic              i_step,
  input  logic              i_last,
  input  muldiv_pkg::xlen_t i_rs1,
  input  muldiv_pkg::xlen_t i_rs2,
  input  logic              i_rs1_signed,
  input  logic              i_rs2_signed,
  input  logic              i_low_half,
  output muldiv_pkg::xlen_t o_mul_res
);
  import muldiv_pkg::*;

  mul_acc_t   prdt_hi_q;
  mul_acc_t   prdt_lo_q;
  logic       sft1_q;
  logic       rs1_sgn;
  logic       rs2_sgn;
  logic [2:0] booth_code;
  logic       sel_zero;
  logic       sel_two;
  logic       sel_sub;
  mul_sum_t   addend;
  mul_sum_t   acc;
  mul_sum_t   sum;
  logic       upd;

  // Extension bits of the 33-bit operands
  assign rs1_sgn = i_rs1_signed & i_rs1[XLEN-1];
  assign rs2_sgn = i_rs2_signed & i_rs2[XLEN-1];

  // Multiplier triplet
  // Load takes the bottom of rs1, the final digit sees the extension bit
  assign booth_code = i_load ? {i_rs1[1:0], 1'b0}
                    : i_last ? {rs1_sgn, prdt_lo_q[0], sft1_q}
                             : {prdt_lo_q[1:0], sft1_q};

  // 000 and 111 add nothing, 011 and 100 take twice the multiplicand
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);
  assign sel_sub  = booth_code[2];

  assign addend = sel_zero ? '0
                : sel_two  ? {rs2_sgn, rs2_sgn, i_rs2, 1'b0}
                           : {rs2_sgn, rs2_sgn, rs2_sgn, i_rs2};

  // High half sign-extended into the adder, empty on load
  assign acc = i_load ? '0 : {prdt_hi_q[XLEN], prdt_hi_q[XLEN], prdt_hi_q};
  assign sum = sel_sub ? (acc - addend) : (acc + addend);

  // Final step stays combinational so the result holds under stall
  assign upd = i_load | (i_step & ~i_last);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      prdt_hi_q <= '0;
      prdt_lo_q <= '0;
      sft1_q    <= 1'b0;
    end else if (upd) begin
      prdt_hi_q <= sum[XLEN+2:2];
      // Two product bits enter on top as the multiplier drains out below
      if (i_load) begin
        prdt_lo_q <= {sum[1:0], rs1_sgn, i_rs1[XLEN-1:2]};
        sft1_q    <= i_rs1[1];
      end else begin
        prdt_lo_q <= {sum[1:0], prdt_lo_q[XLEN:2]};
        sft1_q    <= prdt_lo_q[1];
      end
    end
  end

  // Low word is already shifted in, high word comes from the last sum
  assign o_mul_res = i_low_half ? prdt_lo_q[XLEN:1] : sum[XLEN-1:0];

endmodule

//--- rtl/muldiv_step_cnt.sv
////////////////////////////////////////////////////////////////////////////
// Exec step counter and last-step flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module muldiv_step_cnt (
  input  logic clk,
  input  logic i_rst,
  input  logic i_start,
  input  logic i_run,
  input  logic i_is_mul,
  output logic o_last
);
  import muldiv_pkg::*;

  cnt_t cnt_q;

  // Accept cycle already did step zero, so counting starts at one
  always_ff @(posedge clk) begin
    if (i_rst) begin
      cnt_q <= '0;
    end else if (i_start) begin
      cnt_q <= cnt_t'(1);
    end else if (i_run & ~o_last) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Count parks on the last step while the result waits
  assign o_last = (cnt_q == cnt_t'(i_is_mul ? MUL_STEPS : DIV_STEPS));

  a_cnt_range: assert property (@(posedge clk) disable iff (i_rst)
    cnt_q <= cnt_t'(DIV_STEPS));

endmodule

//--- rtl/muldiv_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Sequencing FSM, datapath strobes and valid/ready handshake
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module muldiv_ctrl (
  input  logic clk,
  input  logic i_rst,
  input  logic i_valid,
  input  logic i_wbck_ready,
  input  logic i_is_mul,
  input  logic i_is_special,
  input  logic i_last,
  input  logic i_need_corr,
  output logic o_ready,
  output logic o_wbck_valid,
  output logic o_start,
  output logic o_run,
  output logic o_load,
  output logic o_step,
  output logic o_check,
  output logic o_quot_corr,
  output logic o_remd_corr
);
  import muldiv_pkg::*;

  muldiv_state_e state_q;
  muldiv_state_e state_d;
  logic          accept;
  logic          done;
  logic          hsk;

  // Regular request seen in idle, special cases never leave idle
  assign accept = (state_q == ST_IDLE) & i_valid & ~i_is_special;

  // Result is on the bus
  // A special case only counts as done while it is actually requested
  assign done = ((state_q == ST_IDLE) & i_valid & i_is_special)
              | ((state_q == ST_EXEC) & i_last & i_is_mul)
              | ((state_q == ST_REMD_CHCK) & ~i_need_corr)
              | (state_q == ST_REMD_CORR);

  // Writeback valid follows the held request, issue ready follows writeback ready
  assign o_wbck_valid = done & i_valid;
  assign o_ready      = done & i_wbck_ready;
  assign hsk          = o_wbck_valid & i_wbck_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        // Divide always goes on to the check, multiply waits for the taker
        if (i_last & ~i_is_mul) begin
          state_d = ST_REMD_CHCK;
        end else if (hsk) begin
          state_d = ST_IDLE;
        end
      end
      ST_REMD_CHCK: begin
        if (i_need_corr) begin
          state_d = ST_QUOT_CORR;
        end else if (hsk) begin
          state_d = ST_IDLE;
        end
      end
      ST_QUOT_CORR: begin
        state_d = ST_REMD_CORR;
      end
      ST_REMD_CORR: begin
        if (hsk) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Strobes
  assign o_start     = accept;
  assign o_load      = accept;
  assign o_run       = (state_q == ST_EXEC);
  assign o_step      = (state_q == ST_EXEC);
  assign o_check     = (state_q == ST_REMD_CHCK);
  assign o_quot_corr = (state_q == ST_QUOT_CORR);
  assign o_remd_corr = (state_q == ST_REMD_CORR);

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // The request must stay up from accept until its result is taken
  a_req_held: assert property (@(posedge clk) disable iff (i_rst)
    (o_wbck_valid || (state_q != ST_IDLE)) |-> i_valid);

  // A stalled result keeps the FSM where it is
  a_stall_hold: assert property (@(posedge clk) disable iff (i_rst)
    (o_wbck_valid && !i_wbck_ready) |=> $stable(state_q));

  a_state_legal: assert property (@(posedge clk) disable iff (i_rst)
    state_q inside {ST_IDLE, ST_EXEC, ST_REMD_CHCK, ST_QUOT_CORR, ST_REMD_CORR});

endmodule

//--- rtl/muldiv_op_route.sv
////////////////////////////////////////////////////////////////////////////
// Operation decode, divide special cases and writeback data select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module muldiv_op_route (
  input  muldiv_pkg::op_t   i_op,
  input  muldiv_pkg::xlen_t i_rs1,
  input  muldiv_pkg::xlen_t i_rs2,
  input  muldiv_pkg::xlen_t i_mul_res,
  input  muldiv_pkg::xlen_t i_div_res,
  output logic              o_is_mul,
  output logic              o_is_special,
  output logic              o_rs1_signed,
  output logic              o_rs2_signed,
  output logic              o_want_rem,
  output muldiv_pkg::xlen_t o_wbck_data
);
  import muldiv_pkg::*;

  logic [1:0] sgn;
  logic       div_by_zero;
  logic       div_ovf;
  xlen_t      min_neg;
  xlen_t      special_res;

  // Operand signedness, rs1 in bit 1 and rs2 in bit 0
  always_comb begin
    case (i_op)
      OP_MUL, OP_MULH, OP_DIV, OP_REM: sgn = 2'b11;
      OP_MULHSU:                       sgn = 2'b10;
      OP_MULHU, OP_DIVU, OP_REMU:      sgn = 2'b00;
    endcase
  end

  assign o_is_mul     = (i_op < OP_DIV);
  assign o_rs1_signed = sgn[1];
  assign o_rs2_signed = sgn[0];
  // Low word for MUL, remainder for REM and REMU
  assign o_want_rem   = (i_op == OP_MUL) | (i_op == OP_REM) | (i_op == OP_REMU);

  // Most negative value, the only dividend that can overflow
  assign min_neg = {1'b1, {(XLEN-1){1'b0}}};

  assign div_by_zero = ~o_is_mul & (i_rs2 == '0);
  // Signed divide of min_neg by minus one
  assign div_ovf     = ~o_is_mul & o_rs2_signed & (&i_rs2) & (i_rs1 == min_neg);
  assign o_is_special = div_by_zero | div_ovf;

  // RISC-V M results for the special cases
  assign special_res = div_by_zero ? (o_want_rem ? i_rs1 : '1)
                                   : (o_want_rem ? '0 : min_neg);

  assign o_wbck_data = o_is_special ? special_res
                     : o_is_mul     ? i_mul_res
                                    : i_div_res;

endmodule

//--- rtl/muldiv_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Widths, operation codes, step counts and controller states of the
// iterative multiply/divide unit
////////////////////////////////////////////////////////////////////////////
package muldiv_pkg;

  // Operand and result width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [2:0]      op_t;

  // Operation codes follow the RISC-V funct3 order
  // Anything below OP_DIV goes to the multiplier
  localparam op_t OP_MUL    = 3'd0;
  localparam op_t OP_MULH   = 3'd1;
  localparam op_t OP_MULHSU = 3'd2;
  localparam op_t OP_MULHU  = 3'd3;
  localparam op_t OP_DIV    = 3'd4;
  localparam op_t OP_DIVU   = 3'd5;
  localparam op_t OP_REM    = 3'd6;
  localparam op_t OP_REMU   = 3'd7;

  // Partial product halves, one guard bit above the word
  typedef logic [XLEN:0]   mul_acc_t;
  // Booth adder, two more bits for the doubled multiplicand
  typedef logic [XLEN+2:0] mul_sum_t;
  // Divider adder and sign-extended partial remainder
  typedef logic [XLEN+1:0] div_acc_t;

  // Radix-4 needs 17 digits, the accept cycle does the first one
  localparam int MUL_STEPS = 16;
  // 33 quotient digits, again the first one in the accept cycle
  localparam int DIV_STEPS = 32;

  // Step counter must reach DIV_STEPS
  localparam int CNT_W = 6;
  typedef logic [CNT_W-1:0] cnt_t;

  // Sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXEC,
    ST_REMD_CHCK,
    ST_QUOT_CORR,
    ST_REMD_CORR
  } muldiv_state_e;

endpackage
